/* tlb_pkg.sv */
package tlb_pkg;

    localparam int VPPN_W    = 19;
    localparam int PPN_W     = 20;
    localparam int ASID_W    = 10;
    localparam int PS_W      = 6;
    localparam int HIT_IDX_W = 8;

    localparam logic [PS_W-1:0] PS_4K = 6'd12;

    // paired-page entry, even page first
    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [PS_W-1:0]   ps;
        logic              g;
        logic [ASID_W-1:0] asid;
        logic [PPN_W-1:0]  ppn0;
        logic [1:0]        plv0;
        logic [1:0]        mat0;
        logic              d0;
        logic              v0;
        logic [PPN_W-1:0]  ppn1;
        logic [1:0]        plv1;
        logic [1:0]        mat1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    typedef struct packed {
        logic                 found;
        logic [HIT_IDX_W-1:0] index;
        logic [PS_W-1:0]      ps;
        logic [PPN_W-1:0]     ppn;
        logic                 v;
        logic                 d;
        logic [1:0]           mat;
        logic [1:0]           plv;
    } tlb_hit_t;

    typedef enum logic [4:0] {
        INV_ALL0              = 5'd0,
        INV_ALL1              = 5'd1,
        INV_GLOBAL            = 5'd2,
        INV_NONGLOBAL         = 5'd3,
        INV_ASID              = 5'd4,
        INV_ASID_VA           = 5'd5,
        INV_GLOBAL_OR_ASID_VA = 5'd6
    } inv_op_e;

    typedef struct packed {
        logic              en;
        inv_op_e           op;
        logic [ASID_W-1:0] asid;
        logic [VPPN_W-1:0] vpn;
    } tlb_inv_t;

    typedef enum logic [2:0] {
        TLBOP_NONE,
        TLBOP_RD,
        TLBOP_WR,
        TLBOP_FILL,
        TLBOP_INV
    } tlb_op_e;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_TLBR,
        EXC_PIF,
        EXC_PIL,
        EXC_PIS,
        EXC_PPI,
        EXC_PME
    } tlb_exc_e;

    // large pages only compare the upper vppn bits
    function automatic logic vppn_match(input logic [PS_W-1:0] ps,
                                        input logic [VPPN_W-1:0] ent_vppn,
                                        input logic [VPPN_W-1:0] vppn);
        if (ps == PS_4K) begin
            return ent_vppn == vppn;
        end
        return ent_vppn[18:10] == vppn[18:10];
    endfunction

endpackage

/* tlb_entry.sv */
`timescale 1ns/1ps

module tlb_entry #(
    parameter int TLB_NUM = 16
) (
    input  logic                       clk,
    // search port 0, instruction fetch
    input  logic                       s0_fetch_i,
    input  logic [tlb_pkg::VPPN_W-1:0] s0_vppn_i,
    input  logic                       s0_odd_page_i,
    input  logic [tlb_pkg::ASID_W-1:0] s0_asid_i,
    output tlb_pkg::tlb_hit_t          s0_hit_o,
    // search port 1, load and store
    input  logic                       s1_fetch_i,
    input  logic [tlb_pkg::VPPN_W-1:0] s1_vppn_i,
    input  logic                       s1_odd_page_i,
    input  logic [tlb_pkg::ASID_W-1:0] s1_asid_i,
    output tlb_pkg::tlb_hit_t          s1_hit_o,
    // write port
    input  logic                       we_i,
    input  logic [$clog2(TLB_NUM)-1:0] w_index_i,
    input  tlb_pkg::tlb_entry_t        w_entry_i,
    // read port
    input  logic [$clog2(TLB_NUM)-1:0] r_index_i,
    output tlb_pkg::tlb_entry_t        r_entry_o,
    input  tlb_pkg::tlb_inv_t          inv_i
);

    import tlb_pkg::*;

    // VA bit 21 sits at vppn bit 8
    localparam int ODD_BIT_2M = 21 - 13;

    tlb_entry_t         ent_q [TLB_NUM];
    logic [TLB_NUM-1:0] e_q;

    logic [1:0]        fetch;
    logic [1:0]        odd_page;
    logic [VPPN_W-1:0] vppn [2];
    logic [ASID_W-1:0] asid [2];

    assign fetch    = {s1_fetch_i, s0_fetch_i};
    assign odd_page = {s1_odd_page_i, s0_odd_page_i};
    assign vppn[0]  = s0_vppn_i;
    assign vppn[1]  = s1_vppn_i;
    assign asid[0]  = s0_asid_i;
    assign asid[1]  = s1_asid_i;

    function automatic logic inv_sel(input tlb_inv_t inv, input tlb_entry_t ent);
        logic va_hit;
        logic asid_hit;
        va_hit   = vppn_match(ent.ps, ent.vppn, inv.vpn);
        asid_hit = ent.asid == inv.asid;
        case (inv.op)
            INV_ALL0, INV_ALL1:    return 1'b1;
            INV_GLOBAL:            return ent.g;
            INV_NONGLOBAL:         return !ent.g;
            INV_ASID:              return !ent.g && asid_hit;
            INV_ASID_VA:           return !ent.g && asid_hit && va_hit;
            INV_GLOBAL_OR_ASID_VA: return (ent.g || asid_hit) && va_hit;
            default:               return 1'b0;
        endcase
    endfunction

    // payload, e is kept apart
    always_ff @(posedge clk) begin
        if (we_i) begin
            ent_q[w_index_i] <= w_entry_i;
        end
    end

    // a write wins over an invalidate
    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_NUM; i++) begin
            if (we_i && int'(w_index_i) == i) begin
                e_q[i] <= w_entry_i.e;
            end else if (inv_i.en && inv_sel(inv_i, ent_q[i])) begin
                e_q[i] <= 1'b0;
            end
        end
    end

    always_comb begin
        r_entry_o   = ent_q[r_index_i];
        r_entry_o.e = e_q[r_index_i];
    end

    for (genvar p = 0; p < 2; p++) begin : g_port
        logic [TLB_NUM-1:0] match_q;
        logic [TLB_NUM-1:0] odd_q;
        tlb_hit_t           hit_c;

        always_ff @(posedge clk) begin
            if (fetch[p]) begin
                for (int i = 0; i < TLB_NUM; i++) begin
                    match_q[i] <= e_q[i]
                                  && (ent_q[i].g || ent_q[i].asid == asid[p])
                                  && vppn_match(ent_q[i].ps, ent_q[i].vppn, vppn[p]);
                    odd_q[i]   <= (ent_q[i].ps == PS_4K) ? odd_page[p]
                                                         : vppn[p][ODD_BIT_2M];
                end
            end
        end

        // later index overrides, so the highest match wins
        always_comb begin
            hit_c = '0;
            for (int i = 0; i < TLB_NUM; i++) begin
                if (match_q[i]) begin
                    hit_c.found = 1'b1;
                    hit_c.index = HIT_IDX_W'(i);
                    hit_c.ps    = ent_q[i].ps;
                    if (odd_q[i]) begin
                        hit_c.ppn = ent_q[i].ppn1;
                        hit_c.v   = ent_q[i].v1;
                        hit_c.d   = ent_q[i].d1;
                        hit_c.mat = ent_q[i].mat1;
                        hit_c.plv = ent_q[i].plv1;
                    end else begin
                        hit_c.ppn = ent_q[i].ppn0;
                        hit_c.v   = ent_q[i].v0;
                        hit_c.d   = ent_q[i].d0;
                        hit_c.mat = ent_q[i].mat0;
                        hit_c.plv = ent_q[i].plv0;
                    end
                end
            end
        end
    end

    assign s0_hit_o = g_port[0].hit_c;
    assign s1_hit_o = g_port[1].hit_c;

endmodule

/* tlb_maint.sv */
`timescale 1ns/1ps

module tlb_maint #(
    parameter int TLB_NUM = 16
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       op_valid_i,
    input  tlb_pkg::tlb_op_e           op_i,
    input  logic [$clog2(TLB_NUM)-1:0] op_index_i,
    input  tlb_pkg::tlb_entry_t        op_entry_i,
    input  tlb_pkg::inv_op_e           inv_op_i,
    input  logic [tlb_pkg::ASID_W-1:0] inv_asid_i,
    input  logic [tlb_pkg::VPPN_W-1:0] inv_vpn_i,
    output tlb_pkg::tlb_entry_t        rd_entry_o,
    output logic                       rd_valid_o,
    // array side
    output logic                       we_o,
    output logic [$clog2(TLB_NUM)-1:0] w_index_o,
    output tlb_pkg::tlb_entry_t        w_entry_o,
    output logic [$clog2(TLB_NUM)-1:0] r_index_o,
    input  tlb_pkg::tlb_entry_t        r_entry_i,
    output tlb_pkg::tlb_inv_t          inv_o
);

    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_NUM);

    logic             is_rd;
    logic             is_fill;
    logic [IDX_W-1:0] fill_ptr_q;
    tlb_entry_t       rd_entry_d;
    tlb_entry_t       rd_entry_q;
    logic             rd_valid_q;

    assign is_rd   = op_valid_i && (op_i == TLBOP_RD);
    assign is_fill = op_valid_i && (op_i == TLBOP_FILL);

    assign we_o      = op_valid_i && (op_i == TLBOP_WR || op_i == TLBOP_FILL);
    assign w_index_o = is_fill ? fill_ptr_q : op_index_i;
    assign w_entry_o = op_entry_i;
    assign r_index_o = op_index_i;

    assign inv_o.en   = op_valid_i && (op_i == TLBOP_INV);
    assign inv_o.op   = inv_op_i;
    assign inv_o.asid = inv_asid_i;
    assign inv_o.vpn  = inv_vpn_i;

    // round-robin fill slot
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fill_ptr_q <= '0;
        end else if (is_fill) begin
            if (fill_ptr_q == IDX_W'(TLB_NUM - 1)) begin
                fill_ptr_q <= '0;
            end else begin
                fill_ptr_q <= fill_ptr_q + 1'b1;
            end
        end
    end

    // empty slot reads back as zeros, ps kept
    always_comb begin
        rd_entry_d = r_entry_i;
        if (!r_entry_i.e) begin
            rd_entry_d    = '0;
            rd_entry_d.ps = r_entry_i.ps;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= is_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (is_rd) begin
            rd_entry_q <= rd_entry_d;
        end
    end

    assign rd_entry_o = rd_entry_q;
    assign rd_valid_o = rd_valid_q;

endmodule

/* tlb_xlate.sv */
`timescale 1ns/1ps

module tlb_xlate #(
    parameter bit STORE_PORT = 1'b0
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fetch_i,
    input  logic [31:0]        va_i,
    input  logic [1:0]         plv_i,
    input  logic               store_i,
    input  tlb_pkg::tlb_hit_t  hit_i,
    output logic               valid_o,
    output logic [31:0]        pa_o,
    output tlb_pkg::tlb_exc_e  exc_o,
    output logic [1:0]         mat_o
);

    import tlb_pkg::*;

    logic        valid_q;
    logic [20:0] off_q;
    logic [1:0]  plv_q;
    logic        store_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_i;
        end
    end

    // access context for the lookup in flight
    always_ff @(posedge clk) begin
        if (fetch_i) begin
            off_q   <= va_i[20:0];
            plv_q   <= plv_i;
            store_q <= STORE_PORT && store_i;
        end
    end

    always_comb begin
        if (hit_i.ps == PS_4K) begin
            pa_o = {hit_i.ppn, off_q[11:0]};
        end else begin
            pa_o = {hit_i.ppn[19:9], off_q};
        end
    end

    // checks in priority order
    always_comb begin
        if (!hit_i.found) begin
            exc_o = EXC_TLBR;
        end else if (!hit_i.v) begin
            if (!STORE_PORT) begin
                exc_o = EXC_PIF;
            end else if (store_q) begin
                exc_o = EXC_PIS;
            end else begin
                exc_o = EXC_PIL;
            end
        end else if (plv_q > hit_i.plv) begin
            exc_o = EXC_PPI;
        end else if (store_q && !hit_i.d) begin
            exc_o = EXC_PME;
        end else begin
            exc_o = EXC_NONE;
        end
    end

    assign valid_o = valid_q;
    assign mat_o   = hit_i.mat;

endmodule

/* tlb_unit.sv */
`timescale 1ns/1ps

module tlb_unit #(
    parameter int TLB_NUM = 16
) (
    input  logic                       clk,
    input  logic                       reset_i,
    // maintenance
    input  logic                       op_valid_i,
    input  tlb_pkg::tlb_op_e           op_i,
    input  logic [$clog2(TLB_NUM)-1:0] op_index_i,
    input  tlb_pkg::tlb_entry_t        op_entry_i,
    input  tlb_pkg::inv_op_e           inv_op_i,
    input  logic [tlb_pkg::ASID_W-1:0] inv_asid_i,
    input  logic [tlb_pkg::VPPN_W-1:0] inv_vpn_i,
    output tlb_pkg::tlb_entry_t        rd_entry_o,
    output logic                       rd_valid_o,
    // fetch port
    input  logic                       s0_fetch_i,
    input  logic [31:0]                s0_va_i,
    input  logic [tlb_pkg::ASID_W-1:0] s0_asid_i,
    input  logic [1:0]                 s0_plv_i,
    output logic                       s0_valid_o,
    output logic [31:0]                s0_pa_o,
    output tlb_pkg::tlb_exc_e          s0_exc_o,
    output logic [1:0]                 s0_mat_o,
    // load/store port
    input  logic                       s1_fetch_i,
    input  logic [31:0]                s1_va_i,
    input  logic [tlb_pkg::ASID_W-1:0] s1_asid_i,
    input  logic [1:0]                 s1_plv_i,
    input  logic                       s1_store_i,
    output logic                       s1_valid_o,
    output logic [31:0]                s1_pa_o,
    output tlb_pkg::tlb_exc_e          s1_exc_o,
    output logic [1:0]                 s1_mat_o
);

    import tlb_pkg::*;

    logic                       we;
    logic [$clog2(TLB_NUM)-1:0] w_index;
    tlb_entry_t                 w_entry;
    logic [$clog2(TLB_NUM)-1:0] r_index;
    tlb_entry_t                 r_entry;
    tlb_inv_t                   inv;
    tlb_hit_t                   s0_hit;
    tlb_hit_t                   s1_hit;

    tlb_maint #(
        .TLB_NUM (TLB_NUM)
    ) u_maint (
        .clk        (clk),
        .reset_i    (reset_i),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .op_index_i (op_index_i),
        .op_entry_i (op_entry_i),
        .inv_op_i   (inv_op_i),
        .inv_asid_i (inv_asid_i),
        .inv_vpn_i  (inv_vpn_i),
        .rd_entry_o (rd_entry_o),
        .rd_valid_o (rd_valid_o),
        .we_o       (we),
        .w_index_o  (w_index),
        .w_entry_o  (w_entry),
        .r_index_o  (r_index),
        .r_entry_i  (r_entry),
        .inv_o      (inv)
    );

    // vppn is VA[31:13], odd page bit for 4 KiB is VA[12]
    tlb_entry #(
        .TLB_NUM (TLB_NUM)
    ) u_entry (
        .clk           (clk),
        .s0_fetch_i    (s0_fetch_i),
        .s0_vppn_i     (s0_va_i[31:13]),
        .s0_odd_page_i (s0_va_i[12]),
        .s0_asid_i     (s0_asid_i),
        .s0_hit_o      (s0_hit),
        .s1_fetch_i    (s1_fetch_i),
        .s1_vppn_i     (s1_va_i[31:13]),
        .s1_odd_page_i (s1_va_i[12]),
        .s1_asid_i     (s1_asid_i),
        .s1_hit_o      (s1_hit),
        .we_i          (we),
        .w_index_i     (w_index),
        .w_entry_i     (w_entry),
        .r_index_i     (r_index),
        .r_entry_o     (r_entry),
        .inv_i         (inv)
    );

    tlb_xlate #(
        .STORE_PORT (1'b0)
    ) u_xlate_if (
        .clk     (clk),
        .reset_i (reset_i),
        .fetch_i (s0_fetch_i),
        .va_i    (s0_va_i),
        .plv_i   (s0_plv_i),
        .store_i (1'b0),
        .hit_i   (s0_hit),
        .valid_o (s0_valid_o),
        .pa_o    (s0_pa_o),
        .exc_o   (s0_exc_o),
        .mat_o   (s0_mat_o)
    );

    tlb_xlate #(
        .STORE_PORT (1'b1)
    ) u_xlate_ls (
        .clk     (clk),
        .reset_i (reset_i),
        .fetch_i (s1_fetch_i),
        .va_i    (s1_va_i),
        .plv_i   (s1_plv_i),
        .store_i (s1_store_i),
        .hit_i   (s1_hit),
        .valid_o (s1_valid_o),
        .pa_o    (s1_pa_o),
        .exc_o   (s1_exc_o),
        .mat_o   (s1_mat_o)
    );

endmodule

/* tlb_unit_checker.sv */
`timescale 1ns/1ps

module tlb_unit_checker (
    input logic                clk,
    input logic                reset_i,
    input logic                rd_valid_i,
    input tlb_pkg::tlb_entry_t rd_entry_i,
    input logic                s0_valid_i,
    input logic [31:0]         s0_pa_i,
    input tlb_pkg::tlb_exc_e   s0_exc_i,
    input logic [1:0]          s0_mat_i,
    input logic                s1_valid_i,
    input logic [31:0]         s1_pa_i,
    input tlb_pkg::tlb_exc_e   s1_exc_i,
    input logic [1:0]          s1_mat_i
);

    import tlb_pkg::*;

    typedef struct packed {
        logic [31:0] pa;
        tlb_exc_e    exc;
        logic [1:0]  mat;
        int          due;
    } pend_t;

    typedef struct packed {
        tlb_entry_t ent;
        int         due;
    } rd_pend_t;

    pend_t      pend0_q [$];
    pend_t      pend1_q [$];
    rd_pend_t   rd_q [$];
    int         cyc = 0;
    int         checks = 0;
    int         errors = 0;
    int         tests = 0;
    int         test_base = 0;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // pushed on the issue edge, the result is sampled two edges later
    task automatic push_xlate(input int port, input logic [31:0] pa, input tlb_exc_e exc,
                              input logic [1:0] mat);
        pend_t p;
        p = '{pa, exc, mat, cyc + 2};
        if (port == 0) begin
            pend0_q.push_back(p);
        end else begin
            pend1_q.push_back(p);
        end
    endtask

    task automatic push_read(input tlb_entry_t ent);
        rd_pend_t r;
        r.ent = ent;
        r.due = cyc + 2;
        rd_q.push_back(r);
    endtask

    task automatic compare(input string sig, input logic [95:0] got, input logic [95:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, sig, got, want);
        end
    endtask

    task automatic check_xlate(input int port, input logic [31:0] pa, input tlb_exc_e exc,
                               input logic [1:0] mat);
        pend_t p;
        if ((port == 0 && pend0_q.size() == 0) || (port == 1 && pend1_q.size() == 0)) begin
            errors++;
            $display("[%0t] port %0d gave a result that no lookup asked for", $time, port);
            return;
        end
        if (port == 0) begin
            p = pend0_q.pop_front();
        end else begin
            p = pend1_q.pop_front();
        end
        if (p.due != cyc) begin
            errors++;
            $display("[%0t] port %0d result came in cycle %0d instead of cycle %0d", $time,
                     port, cyc, p.due);
        end
        compare($sformatf("s%0d_exc_o", port), exc, p.exc);
        // mat is defined on a hit and pa only without an exception
        if (p.exc != EXC_TLBR) begin
            compare($sformatf("s%0d_mat_o", port), mat, p.mat);
        end
        if (p.exc == EXC_NONE) begin
            compare($sformatf("s%0d_pa_o", port), pa, p.pa);
        end
    endtask

    task automatic drop_missing(input int port);
        pend_t p;
        if ((port == 0 && pend0_q.size() == 0) || (port == 1 && pend1_q.size() == 0)) begin
            return;
        end
        p = (port == 0) ? pend0_q[0] : pend1_q[0];
        if (p.due > cyc) begin
            return;
        end
        if (port == 0) begin
            p = pend0_q.pop_front();
        end else begin
            p = pend1_q.pop_front();
        end
        errors++;
        $display("[%0t] port %0d gave no result for the lookup due in cycle %0d", $time,
                 port, p.due);
    endtask

    task automatic check_read();
        rd_pend_t r;
        if (rd_q.size() == 0) begin
            errors++;
            $display("[%0t] read data came back without a read op", $time);
            return;
        end
        r = rd_q.pop_front();
        if (r.due != cyc) begin
            errors++;
            $display("[%0t] read data came in cycle %0d instead of cycle %0d", $time, cyc,
                     r.due);
        end
        compare("rd_entry_o", rd_entry_i, r.ent);
    endtask

    task automatic drop_missing_read();
        rd_pend_t r;
        if (rd_q.size() == 0) begin
            return;
        end
        r = rd_q[0];
        if (r.due > cyc) begin
            return;
        end
        r = rd_q.pop_front();
        errors++;
        $display("[%0t] no read data came for the read due in cycle %0d", $time, r.due);
    endtask

    always @(posedge clk) begin
        if (!reset_i) begin
            if (s0_valid_i) begin
                check_xlate(0, s0_pa_i, s0_exc_i, s0_mat_i);
            end else begin
                drop_missing(0);
            end
            if (s1_valid_i) begin
                check_xlate(1, s1_pa_i, s1_exc_i, s1_mat_i);
            end else begin
                drop_missing(1);
            end
            if (rd_valid_i) begin
                check_read();
            end else begin
                drop_missing_read();
            end
        end
    end

    task automatic end_test(input string name);
        while (pend0_q.size() + pend1_q.size() + rd_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        tests++;
        $display("test %s: %s (%0d errors)", name, (errors == test_base) ? "ok" : "FAILED",
                 errors - test_base);
        test_base = errors;
    endtask

    task automatic report();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

endmodule

/* tlb_unit_tb.sv */
`timescale 1ns/1ps

module tlb_unit_tb;

    import tlb_pkg::*;

    localparam int TLB_NUM = 16;
    localparam int IDX_W   = $clog2(TLB_NUM);
    localparam int N_RAND  = 24;
    localparam int N_LOOK  = 60;
    localparam int N_WL    = 12;
    // op and lookup cycles issued by all tests together
    localparam int N_OPS   = (1 + 2 * TLB_NUM + N_RAND) + (2 * TLB_NUM + 3) + (TLB_NUM + N_LOOK)
                             + 2 * N_WL + 7 * (2 * TLB_NUM + 1);
    localparam int LIMIT   = 4 * N_OPS + 200;

    typedef struct packed {
        logic              fetch;
        logic [31:0]       va;
        logic [ASID_W-1:0] asid;
        logic [1:0]        plv;
        logic              store;
    } lookup_t;

    typedef struct packed {
        logic [31:0] pa;
        tlb_exc_e    exc;
        logic [1:0]  mat;
    } xlate_t;

    logic              clk;
    logic              reset_i;
    logic              op_valid;
    tlb_op_e           op;
    logic [IDX_W-1:0]  op_index;
    tlb_entry_t        op_entry;
    inv_op_e           inv_op;
    logic [ASID_W-1:0] inv_asid;
    logic [VPPN_W-1:0] inv_vpn;
    lookup_t           s0_req;
    lookup_t           s1_req;
    tlb_entry_t        rd_entry;
    logic              rd_valid;
    logic              s0_valid;
    logic              s1_valid;
    logic [31:0]       s0_pa;
    logic [31:0]       s1_pa;
    tlb_exc_e          s0_exc;
    tlb_exc_e          s1_exc;
    logic [1:0]        s0_mat;
    logic [1:0]        s1_mat;

    tlb_entry_t        model [TLB_NUM];
    int                fill_ptr;
    logic [31:0]       lfsr;

    tlb_unit #(.TLB_NUM(TLB_NUM)) dut (
        .clk(clk), .reset_i(reset_i),
        .op_valid_i(op_valid), .op_i(op), .op_index_i(op_index), .op_entry_i(op_entry),
        .inv_op_i(inv_op), .inv_asid_i(inv_asid), .inv_vpn_i(inv_vpn),
        .rd_entry_o(rd_entry), .rd_valid_o(rd_valid),
        .s0_fetch_i(s0_req.fetch), .s0_va_i(s0_req.va), .s0_asid_i(s0_req.asid),
        .s0_plv_i(s0_req.plv), .s0_valid_o(s0_valid), .s0_pa_o(s0_pa),
        .s0_exc_o(s0_exc), .s0_mat_o(s0_mat),
        .s1_fetch_i(s1_req.fetch), .s1_va_i(s1_req.va), .s1_asid_i(s1_req.asid),
        .s1_plv_i(s1_req.plv), .s1_store_i(s1_req.store), .s1_valid_o(s1_valid),
        .s1_pa_o(s1_pa), .s1_exc_o(s1_exc), .s1_mat_o(s1_mat)
    );

    tlb_unit_checker u_chk (
        .clk(clk), .reset_i(reset_i), .rd_valid_i(rd_valid), .rd_entry_i(rd_entry),
        .s0_valid_i(s0_valid), .s0_pa_i(s0_pa), .s0_exc_i(s0_exc), .s0_mat_i(s0_mat),
        .s1_valid_i(s1_valid), .s1_pa_i(s1_pa), .s1_exc_i(s1_exc), .s1_mat_i(s1_mat)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic tlb_entry_t rand_entry();
        tlb_entry_t  t;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a    = rand_bits(32);
        b    = rand_bits(32);
        c    = rand_bits(25);
        t    = {a, b, c[24:0]};
        t.ps = t.ps[0] ? 6'd21 : 6'd12;
        return t;
    endfunction

    // present entry, asid from a small set so invalidates collide
    function automatic tlb_entry_t live_entry();
        tlb_entry_t t;
        t      = rand_entry();
        t.e    = 1'b1;
        t.asid = ASID_W'(t.asid[1:0]);
        return t;
    endfunction

    function automatic logic page_eq(input tlb_entry_t t, input logic [VPPN_W-1:0] vppn);
        if (t.ps == 6'd12) begin
            return t.vppn == vppn;
        end
        return t.vppn[18:10] == vppn[18:10];
    endfunction

    function automatic logic [31:0] target_va(input tlb_entry_t t);
        logic [31:0] r;
        r = rand_bits((t.ps == 6'd12) ? 13 : 23);
        if (t.ps == 6'd12) begin
            return {t.vppn, r[12:0]};
        end
        return {t.vppn[18:10], r[22:0]};
    endfunction

    function automatic lookup_t rand_req(input tlb_entry_t t);
        lookup_t     q;
        logic [31:0] r;
        q.fetch = 1'b1;
        q.va    = target_va(t);
        r       = rand_bits(14);
        q.asid  = r[13] ? t.asid : r[9:0];
        q.plv   = r[11:10];
        q.store = r[12];
        return q;
    endfunction

    function automatic xlate_t ref_search(input lookup_t rq, input bit data_port);
        xlate_t           x;
        tlb_entry_t       t;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic             d;
        logic             v;
        int               hit;
        x   = '0;
        hit = -1;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (model[i].e && (model[i].g || model[i].asid == rq.asid)
                && page_eq(model[i], rq.va[31:13])) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            x.exc = EXC_TLBR;
            return x;
        end
        t = model[hit];
        if ((t.ps == 6'd12) ? rq.va[12] : rq.va[21]) begin
            {ppn, plv, x.mat, d, v} = {t.ppn1, t.plv1, t.mat1, t.d1, t.v1};
        end else begin
            {ppn, plv, x.mat, d, v} = {t.ppn0, t.plv0, t.mat0, t.d0, t.v0};
        end
        x.pa = (t.ps == 6'd12) ? {ppn, rq.va[11:0]} : {ppn[19:9], rq.va[20:0]};
        if (!v) begin
            x.exc = !data_port ? EXC_PIF : (rq.store ? EXC_PIS : EXC_PIL);
        end else if (rq.plv > plv) begin
            x.exc = EXC_PPI;
        end else if (data_port && rq.store && !d) begin
            x.exc = EXC_PME;
        end else begin
            x.exc = EXC_NONE;
        end
        return x;
    endfunction

    function automatic tlb_entry_t read_ref(input tlb_entry_t t);
        tlb_entry_t r;
        r    = '0;
        r.ps = t.ps;
        return t.e ? t : r;
    endfunction

    function automatic logic inv_hits(input tlb_entry_t t, input inv_op_e k,
                                      input logic [ASID_W-1:0] a, input logic [VPPN_W-1:0] vpn);
        case (k)
            INV_ALL0, INV_ALL1:    return 1'b1;
            INV_GLOBAL:            return t.g;
            INV_NONGLOBAL:         return !t.g;
            INV_ASID:              return !t.g && t.asid == a;
            INV_ASID_VA:           return !t.g && t.asid == a && page_eq(t, vpn);
            INV_GLOBAL_OR_ASID_VA: return (t.g || t.asid == a) && page_eq(t, vpn);
            default:               return 1'b0;
        endcase
    endfunction

    task automatic do_op(input tlb_op_e o, input logic [IDX_W-1:0] idx, input tlb_entry_t t,
                         input inv_op_e k, input logic [ASID_W-1:0] a,
                         input logic [VPPN_W-1:0] vpn);
        @(posedge clk);
        op_valid     <= 1'b1;
        op           <= o;
        op_index     <= idx;
        op_entry     <= t;
        inv_op       <= k;
        inv_asid     <= a;
        inv_vpn      <= vpn;
        s0_req.fetch <= 1'b0;
        s1_req.fetch <= 1'b0;
        case (o)
            TLBOP_WR: begin
                model[idx] = t;
            end
            TLBOP_FILL: begin
                model[fill_ptr] = t;
                fill_ptr        = (fill_ptr + 1) % TLB_NUM;
            end
            TLBOP_RD: begin
                u_chk.push_read(read_ref(model[idx]));
            end
            TLBOP_INV: begin
                for (int i = 0; i < TLB_NUM; i++) begin
                    if (inv_hits(model[i], k, a, vpn)) begin
                        model[i].e = 1'b0;
                    end
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic lookup(input lookup_t r0, input lookup_t r1);
        xlate_t x;
        @(posedge clk);
        op_valid <= 1'b0;
        s0_req   <= r0;
        s1_req   <= r1;
        if (r0.fetch) begin
            x = ref_search(r0, 1'b0);
            u_chk.push_xlate(0, x.pa, x.exc, x.mat);
        end
        if (r1.fetch) begin
            x = ref_search(r1, 1'b1);
            u_chk.push_xlate(1, x.pa, x.exc, x.mat);
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < TLB_NUM; i++) begin
            do_op(TLBOP_RD, IDX_W'(i), '0, INV_ALL0, '0, '0);
        end
    endtask

    task automatic populate();
        for (int i = 0; i < TLB_NUM; i++) begin
            do_op(TLBOP_WR, IDX_W'(i), live_entry(), INV_ALL0, '0, '0);
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        op_valid     <= 1'b0;
        s0_req.fetch <= 1'b0;
        s1_req.fetch <= 1'b0;
        u_chk.end_test(name);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main
        tlb_entry_t       t;
        lookup_t          r0;
        lookup_t          r1;
        logic [IDX_W-1:0] idx;
        lfsr     = 32'h8c8d_7e05;
        fill_ptr = 0;
        reset_i  = 1'b1;
        op_valid = 1'b0;
        op       = TLBOP_NONE;
        op_index = '0;
        op_entry = '0;
        inv_op   = INV_ALL0;
        inv_asid = '0;
        inv_vpn  = '0;
        s0_req   = '0;
        s1_req   = '0;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        // e bits random here, so empty slots read back too
        do_op(TLBOP_INV, '0, '0, INV_ALL0, '0, '0);
        for (int i = 0; i < TLB_NUM; i++) begin
            do_op(TLBOP_WR, IDX_W'(i), rand_entry(), INV_ALL0, '0, '0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            idx = rand_bits(IDX_W);
            if (rand_bits(1)) begin
                do_op(TLBOP_WR, idx, rand_entry(), INV_ALL0, '0, '0);
            end else begin
                do_op(TLBOP_RD, idx, '0, INV_ALL0, '0, '0);
            end
        end
        read_all();
        finish_test("write_read");

        // wraps past the last slot
        for (int i = 0; i < TLB_NUM + 3; i++) begin
            do_op(TLBOP_FILL, '0, rand_entry(), INV_ALL0, '0, '0);
        end
        read_all();
        finish_test("fill");

        populate();
        for (int i = 0; i < N_LOOK; i++) begin
            r0 = rand_req(model[rand_bits(IDX_W)]);
            r1 = rand_req(model[rand_bits(IDX_W)]);
            lookup(r0, r1);
        end
        finish_test("translate");

        // lookup right behind the write, port 1 with a foreign asid
        for (int i = 0; i < N_WL; i++) begin
            idx = rand_bits(IDX_W);
            t   = live_entry();
            do_op(TLBOP_WR, idx, t, INV_ALL0, '0, '0);
            r0      = rand_req(t);
            r0.asid = t.asid;
            r1      = r0;
            r1.asid = t.asid ^ 10'h155;
            lookup(r0, r1);
        end
        finish_test("asid_global");

        for (int k = 0; k < 7; k++) begin
            populate();
            t = model[rand_bits(IDX_W)];
            do_op(TLBOP_INV, '0, '0, inv_op_e'(k), t.asid, t.vppn);
            for (int i = 0; i < TLB_NUM; i++) begin
                r0      = rand_req(model[i]);
                r0.asid = model[i].asid;
                lookup(r0, '0);
            end
            finish_test($sformatf("invalidate_%0d", k));
        end

        u_chk.report();
        if (u_chk.errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tlb_unit.f */
tlb_pkg.sv
tlb_entry.sv
tlb_maint.sv
tlb_xlate.sv
tlb_unit.sv
tlb_unit_checker.sv
tlb_unit_tb.sv
